//--- hdl/mem_pkg.sv
// shared bus widths, command and size encodings and fetch constants, referenced as mem_pkg::name
package mem_pkg;

    ////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////

    // byte address width
    localparam int xlen = 32;

    // one memory block, also one fetch block
    localparam int block_bits = 64;

    // response and tag width, zero means no tag
    localparam int mem_tag_bits = 4;

    ////////////////////////////////////////
    // command and size encodings
    ////////////////////////////////////////

    // memory bus command
    typedef enum logic [1:0] {
        // idle bus
        bus_none  = 2'h0,
        // read one block, data comes back with the tag
        bus_load  = 2'h1,
        // write, done once the memory accepts it
        bus_store = 2'h2
    } bus_command_t;

    // access size, passed to memory as given by the requester
    typedef enum logic [1:0] {
        // 8 bits
        byte_size   = 2'h0,
        // 16 bits
        half_size   = 2'h1,
        // 32 bits
        word_size   = 2'h2,
        // 64 bits, always used for fetch
        double_size = 2'h3
    } mem_size_t;

    ////////////////////////////////////////
    // fetch constants
    ////////////////////////////////////////

    // first block fetched after reset
    localparam logic [xlen-1:0] fetch_reset_addr = 32'h0000_0000;

    // address step from one fetch block to the next
    localparam logic [xlen-1:0] block_bytes = 32'd8;

endpackage

//--- hdl/mem_req_if.sv
// one requester's command path to the memory arbiter, with requester and arbiter modports
`timescale 1ns/10ps

interface mem_req_if (
    // sampling clock for checks on the arbiter side
    input logic clock
);

    // held by the requester until a nonzero response comes back
    mem_pkg::bus_command_t             command;
    logic [mem_pkg::xlen-1:0]          addr;
    logic [mem_pkg::block_bits-1:0]    wdata;
    mem_pkg::mem_size_t                size;

    // tag of the accepted command, zero while not granted or stalled
    logic [mem_pkg::mem_tag_bits-1:0]  response;

    // fetch or data side
    modport requester (
        output command,
        output addr,
        output wdata,
        output size,
        input  response
    );

    // arbiter side, sees the clock for its checks
    modport arbiter (
        input  clock,
        input  command,
        input  addr,
        input  wdata,
        input  size,
        output response
    );

endinterface

//--- hdl/fetch_unit.sv
// sequential instruction block fetch with one tag in flight, instantiated by the memory port top
`timescale 1ns/10ps

module fetch_unit #(
    parameter int return_latency_max = 8
) (
    input  logic                               clock,
    input  logic                               reset,
    mem_req_if.requester                       req,
    input  logic [mem_pkg::mem_tag_bits-1:0]   mem_tag,
    input  logic [mem_pkg::block_bits-1:0]     mem_data,
    output logic                               fetch_valid,
    output logic [mem_pkg::xlen-1:0]           fetch_addr,
    output logic [mem_pkg::block_bits-1:0]     fetch_data
);

    localparam int wait_bits = $clog2(return_latency_max + 1);
    localparam logic [wait_bits-1:0] wait_limit = wait_bits'(return_latency_max);

    // address of the next block to request
    logic [mem_pkg::xlen-1:0]          next_addr_q;
    // address of the block in flight
    logic [mem_pkg::xlen-1:0]          block_addr_q;
    // tag handed out by memory on acceptance
    logic [mem_pkg::mem_tag_bits-1:0]  tag_q;
    // high while a request is on the bus, low while waiting for the tag
    logic                              requesting_q;
    // cycles since acceptance
    logic [wait_bits-1:0]              wait_q;

    logic accepted;
    logic tag_hit;

    ////////////////////////////////////////
    // request and return
    ////////////////////////////////////////

    // tag back for our block
    assign tag_hit = !requesting_q && (mem_tag != '0) && (mem_tag == tag_q);

    // command accepted under the response tag
    assign accepted = (req.command != mem_pkg::bus_none) && (req.response != '0);

    // next request leaves in the same cycle as the returning block
    assign req.command = (requesting_q || tag_hit) ? mem_pkg::bus_load : mem_pkg::bus_none;
    assign req.addr    = next_addr_q;
    assign req.wdata   = '0;
    assign req.size    = mem_pkg::double_size;

    // one cycle pulse per returned block
    assign fetch_valid = tag_hit;
    assign fetch_addr  = block_addr_q;
    assign fetch_data  = mem_data;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            requesting_q <= 1'b1;
            next_addr_q  <= mem_pkg::fetch_reset_addr;
            tag_q        <= '0;
        end else if (accepted) begin
            // wait for this tag, step to the following block
            requesting_q <= 1'b0;
            tag_q        <= req.response;
            next_addr_q  <= next_addr_q + mem_pkg::block_bytes;
        end else if (tag_hit) begin
            // block back but the new request was not taken yet
            requesting_q <= 1'b1;
        end
    end

    // address of the block in flight
    always_ff @(posedge clock) begin
        if (accepted) begin
            block_addr_q <= next_addr_q;
        end
    end

    ////////////////////////////////////////
    // return latency check
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wait_q <= '0;
        end else if (accepted) begin
            wait_q <= wait_bits'(1);
        end else if (!requesting_q && !tag_hit && (wait_q < wait_limit)) begin
            wait_q <= wait_q + 1'b1;
        end
    end

    // tag must come back by the last allowed cycle
    a_fetch_tag_in_time: assert property (
        @(posedge clock) disable iff (reset)
        (!requesting_q && (wait_q == wait_limit)) |-> tag_hit
    ) else $error("fetch tag not returned within %0d cycles", return_latency_max);

endmodule

//--- hdl/data_unit.sv
// single load or store handler with tag matching for load data inside the memory port top
`timescale 1ns/10ps

module data_unit #(
    parameter int return_latency_max = 8
) (
    input  logic                               clock,
    input  logic                               reset,
    input  mem_pkg::bus_command_t              data_command,
    input  logic [mem_pkg::xlen-1:0]           data_addr,
    input  logic [mem_pkg::block_bits-1:0]     data_wdata,
    input  mem_pkg::mem_size_t                 data_size,
    mem_req_if.requester                       req,
    input  logic [mem_pkg::mem_tag_bits-1:0]   mem_tag,
    input  logic [mem_pkg::block_bits-1:0]     mem_data,
    output logic                               data_ready,
    output logic                               load_valid,
    output logic [mem_pkg::block_bits-1:0]     load_data,
    output logic                               store_done
);

    localparam int wait_bits = $clog2(return_latency_max + 1);
    localparam logic [wait_bits-1:0] wait_limit = wait_bits'(return_latency_max);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_wait_load
    } state_t;

    state_t                            state_q;
    mem_pkg::bus_command_t             cmd_q;
    logic [mem_pkg::xlen-1:0]          addr_q;
    logic [mem_pkg::block_bits-1:0]    wdata_q;
    mem_pkg::mem_size_t                size_q;
    logic [mem_pkg::mem_tag_bits-1:0]  tag_q;
    logic [wait_bits-1:0]              wait_q;

    logic capture;
    logic accepted;
    logic load_hit;

    ////////////////////////////////////////
    // handshake
    ////////////////////////////////////////

    assign data_ready = (state_q == st_idle);
    assign capture    = data_ready && (data_command != mem_pkg::bus_none);
    assign accepted   = (state_q == st_request) && (req.response != '0);
    assign load_hit   = (state_q == st_wait_load) && (mem_tag != '0) && (mem_tag == tag_q);

    // operation shown to the arbiter from the cycle after capture
    assign req.command = (state_q == st_request) ? cmd_q : mem_pkg::bus_none;
    assign req.addr    = addr_q;
    assign req.wdata   = wdata_q;
    assign req.size    = size_q;

    // store is done once memory takes it
    assign store_done = accepted && (cmd_q == mem_pkg::bus_store);
    assign load_valid = load_hit;
    assign load_data  = mem_data;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state_q <= st_idle;
            cmd_q   <= mem_pkg::bus_none;
            tag_q   <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (capture) begin
                        state_q <= st_request;
                        cmd_q   <= data_command;
                    end
                end
                st_request: begin
                    if (accepted) begin
                        // loads wait for their tag
                        if (cmd_q == mem_pkg::bus_store) begin
                            state_q <= st_idle;
                        end else begin
                            state_q <= st_wait_load;
                            tag_q   <= req.response;
                        end
                    end
                end
                st_wait_load: begin
                    if (load_hit) begin
                        state_q <= st_idle;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // captured operation fields
    always_ff @(posedge clock) begin
        if (capture) begin
            addr_q  <= data_addr;
            wdata_q <= data_wdata;
            size_q  <= data_size;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wait_q <= '0;
        end else if (accepted) begin
            wait_q <= wait_bits'(1);
        end else if ((state_q == st_wait_load) && !load_hit && (wait_q < wait_limit)) begin
            wait_q <= wait_q + 1'b1;
        end
    end

    // a strobe that arrives while busy would be dropped
    a_no_capture_busy: assert property (
        @(posedge clock) disable iff (reset)
        !data_ready |-> (data_command == mem_pkg::bus_none)
    ) else $error("data strobe arrived while busy");

    // load tag bounded like fetch
    a_load_tag_in_time: assert property (
        @(posedge clock) disable iff (reset)
        ((state_q == st_wait_load) && (wait_q == wait_limit)) |-> load_hit
    ) else $error("load tag not returned within %0d cycles", return_latency_max);

endmodule

//--- hdl/mem_arbiter.sv
// data-first arbiter driving the shared memory bus and routing the acceptance response
`timescale 1ns/10ps

module mem_arbiter (
    mem_req_if.arbiter                         fetch_req,
    mem_req_if.arbiter                         data_req,
    input  logic [mem_pkg::mem_tag_bits-1:0]   mem_response,
    output mem_pkg::bus_command_t              proc2mem_command,
    output logic [mem_pkg::xlen-1:0]           proc2mem_addr,
    output logic [mem_pkg::block_bits-1:0]     proc2mem_data,
    output mem_pkg::mem_size_t                 proc2mem_size
);

    // data side owns the bus whenever it asks
    logic data_grant;

    assign data_grant = (data_req.command != mem_pkg::bus_none);

    ////////////////////////////////////////
    // bus drive
    ////////////////////////////////////////

    always_comb begin
        if (data_grant) begin
            // size passes through unchanged
            proc2mem_command = data_req.command;
            proc2mem_addr    = data_req.addr;
            proc2mem_data    = data_req.wdata;
            proc2mem_size    = data_req.size;
        end else begin
            // fetch side presents bus_load at double_size or bus_none while waiting
            proc2mem_command = fetch_req.command;
            proc2mem_addr    = fetch_req.addr;
            proc2mem_data    = fetch_req.wdata;
            proc2mem_size    = fetch_req.size;
        end
    end

    ////////////////////////////////////////
    // response routing
    ////////////////////////////////////////

    // loser sees zero and keeps holding
    assign data_req.response  = data_grant ? mem_response : '0;
    assign fetch_req.response = data_grant ? '0 : mem_response;

    // a tag only comes back for a command that is on the bus
    a_resp_to_grant: assert property (
        @(posedge fetch_req.clock)
        (mem_response != '0) |-> (proc2mem_command != mem_pkg::bus_none)
    ) else $error("memory response with no command on the bus");

endmodule

//--- hdl/mem_port_top.sv
// memory port top level, shares one memory bus between instruction fetch and data accesses
`timescale 1ns/10ps

module mem_port_top #(
    parameter int return_latency_max = 8
) (
    input  logic                               clock,
    input  logic                               reset,

    // data side strobes
    input  mem_pkg::bus_command_t              data_command,
    input  logic [mem_pkg::xlen-1:0]           data_addr,
    input  logic [mem_pkg::block_bits-1:0]     data_wdata,
    input  mem_pkg::mem_size_t                 data_size,

    // from memory
    input  logic [mem_pkg::mem_tag_bits-1:0]   mem_response,
    input  logic [mem_pkg::mem_tag_bits-1:0]   mem_tag,
    input  logic [mem_pkg::block_bits-1:0]     mem_data,

    // to memory
    output mem_pkg::bus_command_t              proc2mem_command,
    output logic [mem_pkg::xlen-1:0]           proc2mem_addr,
    output logic [mem_pkg::block_bits-1:0]     proc2mem_data,
    output mem_pkg::mem_size_t                 proc2mem_size,

    // data side results
    output logic                               data_ready,
    output logic                               load_valid,
    output logic                               store_done,
    output logic [mem_pkg::block_bits-1:0]     load_data,

    // fetch stream
    output logic                               fetch_valid,
    output logic [mem_pkg::block_bits-1:0]     fetch_data,
    output logic [mem_pkg::xlen-1:0]           fetch_addr
);

    ////////////////////////////////////////
    // requester paths
    ////////////////////////////////////////

    mem_req_if fetch_req (.clock(clock));
    mem_req_if data_req (.clock(clock));

    ////////////////////////////////////////
    // units
    ////////////////////////////////////////

    // returned tag and data fan out to both units
    fetch_unit #(
        .return_latency_max(return_latency_max)
    ) u_fetch (
        .clock       (clock),
        .reset       (reset),
        .req         (fetch_req.requester),
        .mem_tag     (mem_tag),
        .mem_data    (mem_data),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data)
    );

    data_unit #(
        .return_latency_max(return_latency_max)
    ) u_data (
        .clock        (clock),
        .reset        (reset),
        .data_command (data_command),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_size    (data_size),
        .req          (data_req.requester),
        .mem_tag      (mem_tag),
        .mem_data     (mem_data),
        .data_ready   (data_ready),
        .load_valid   (load_valid),
        .load_data    (load_data),
        .store_done   (store_done)
    );

    mem_arbiter u_arbiter (
        .fetch_req        (fetch_req.arbiter),
        .data_req         (data_req.arbiter),
        .mem_response     (mem_response),
        .proc2mem_command (proc2mem_command),
        .proc2mem_addr    (proc2mem_addr),
        .proc2mem_data    (proc2mem_data),
        .proc2mem_size    (proc2mem_size)
    );

endmodule

//--- sim/tb_mem_model.sv
// behavioral memory for the memory port testbench with random accept and fixed latency tag return
`timescale 1ns/10ps

module tb_mem_model (
    input  logic                              clock,
    input  logic                              reset,
    input  mem_pkg::bus_command_t             command,
    input  logic [mem_pkg::xlen-1:0]          addr,
    input  logic [mem_pkg::block_bits-1:0]    wdata,
    output logic [mem_pkg::mem_tag_bits-1:0]  response,
    output logic [mem_pkg::mem_tag_bits-1:0]  tag,
    output logic [mem_pkg::block_bits-1:0]    data
);

    localparam int return_latency = 3;
    localparam logic [31:0] lfsr_seed = 32'h1aa0_62b4;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    // sparse block storage keyed by block address
    logic [mem_pkg::block_bits-1:0]  blocks [logic [mem_pkg::xlen-1:0]];

    logic [31:0]                                               lfsr_q;
    logic [mem_pkg::mem_tag_bits-1:0]                          next_tag_q;
    logic [return_latency-1:0][mem_pkg::mem_tag_bits-1:0]      tag_pipe_q;
    logic [return_latency-1:0][mem_pkg::block_bits-1:0]        data_pipe_q;
    logic [mem_pkg::xlen-1:0]                                  block_addr;
    logic                                                      accept;
    logic                                                      load_accept;

    // right shifting galois form with one step per random bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ lfsr_taps;
        end
        return state >> 1;
    endfunction

    // unwritten blocks read back as their own address in both halves
    function automatic logic [mem_pkg::block_bits-1:0] read_block(
        input logic [mem_pkg::xlen-1:0] a
    );
        if (blocks.exists(a)) begin
            return blocks[a];
        end
        return {a, a};
    endfunction

    ////////////////////////////////////////
    // accept and return
    ////////////////////////////////////////

    assign block_addr  = {addr[mem_pkg::xlen-1:3], 3'b000};
    assign accept      = !reset && (command != mem_pkg::bus_none) && lfsr_q[0];
    assign load_accept = accept && (command == mem_pkg::bus_load);
    assign response    = accept ? next_tag_q : '0;

    // oldest pipe stage is the return cycle
    assign tag  = tag_pipe_q[return_latency-1];
    assign data = data_pipe_q[return_latency-1];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lfsr_q      <= lfsr_seed;
            next_tag_q  <= 4'h1;
            tag_pipe_q  <= '0;
            data_pipe_q <= '0;
        end else begin
            if (command != mem_pkg::bus_none) begin
                // a random bit is used only when a command waits for accept
                lfsr_q <= lfsr_step(lfsr_q);
            end
            // only loads get a tag back since stores finish on accept
            tag_pipe_q  <= {tag_pipe_q[return_latency-2:0], load_accept ? next_tag_q : 4'h0};
            data_pipe_q <= {data_pipe_q[return_latency-2:0],
                            load_accept ? read_block(block_addr) : 64'h0};
            if (accept) begin
                // tags run 1 to 15 and zero stays free for none
                next_tag_q <= (next_tag_q == 4'hf) ? 4'h1 : next_tag_q + 4'h1;
            end
        end
    end

    // one command per cycle so a load never reads in the cycle of a store
    // a store writes the whole block whatever its size
    always @(posedge clock) begin
        if (accept && (command == mem_pkg::bus_store)) begin
            blocks[block_addr] = wdata;
        end
    end

endmodule

//--- sim/mem_port_tb.sv
// testbench for the memory port that replays the data patterns and watches the fetch stream
`timescale 1ns/10ps

module mem_port_tb;

    localparam int return_latency_max = 6;
    localparam int reset_cycles       = 8;
    localparam int op_timeout         = 100;
    localparam int fetch_target       = 24;
    localparam int fetch_timeout      = 400;

    logic                               clock;
    logic                               reset;
    mem_pkg::bus_command_t              data_command;
    logic [mem_pkg::xlen-1:0]           data_addr;
    logic [mem_pkg::block_bits-1:0]     data_wdata;
    mem_pkg::mem_size_t                 data_size;
    logic [mem_pkg::mem_tag_bits-1:0]   mem_response;
    logic [mem_pkg::mem_tag_bits-1:0]   mem_tag;
    logic [mem_pkg::block_bits-1:0]     mem_data;
    mem_pkg::bus_command_t              proc2mem_command;
    logic [mem_pkg::xlen-1:0]           proc2mem_addr;
    logic [mem_pkg::block_bits-1:0]     proc2mem_data;
    mem_pkg::mem_size_t                 proc2mem_size;
    logic                               data_ready;
    logic                               load_valid;
    logic                               store_done;
    logic [mem_pkg::block_bits-1:0]     load_data;
    logic                               fetch_valid;
    logic [mem_pkg::block_bits-1:0]     fetch_data;
    logic [mem_pkg::xlen-1:0]           fetch_addr;

    // five words per operation
    logic [63:0] pattern_words [0:127];

    int   checks;
    int   mismatches;
    int   failures;
    int   fetch_count;
    int   store_pulses;
    int   load_pulses;
    // high from capture until the data op is accepted
    logic data_on_bus;
    logic run_done;

    always #2 clock = ~clock;

    mem_port_top #(
        .return_latency_max(return_latency_max)
    ) u_dut (
        .clock(clock), .reset(reset),
        .data_command(data_command), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_size(data_size),
        .mem_response(mem_response), .mem_tag(mem_tag), .mem_data(mem_data),
        .proc2mem_command(proc2mem_command), .proc2mem_addr(proc2mem_addr),
        .proc2mem_data(proc2mem_data), .proc2mem_size(proc2mem_size),
        .data_ready(data_ready), .load_valid(load_valid), .store_done(store_done),
        .load_data(load_data), .fetch_valid(fetch_valid),
        .fetch_data(fetch_data), .fetch_addr(fetch_addr)
    );

    tb_mem_model u_mem (
        .clock(clock), .reset(reset),
        .command(proc2mem_command), .addr(proc2mem_addr),
        .wdata(proc2mem_data),
        .response(mem_response), .tag(mem_tag), .data(mem_data)
    );

    ////////////////////////////////////////
    // reporting
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("Failure: %s", what);
    endtask

    ////////////////////////////////////////
    // fetch stream and bus monitor
    ////////////////////////////////////////

    task automatic watch_bus();
        logic [mem_pkg::xlen-1:0] exp_fetch_addr;
        logic [mem_pkg::xlen-1:0] held_addr;
        logic                     held;
        exp_fetch_addr = mem_pkg::fetch_reset_addr;
        held_addr      = '0;
        held           = 1'b0;
        while (!run_done) begin
            @(negedge clock);
            if (fetch_valid) begin
                // unwritten block holds its address in both halves
                check_value("fetch addr", 64'(exp_fetch_addr), 64'(fetch_addr));
                check_value("fetch data", {exp_fetch_addr, exp_fetch_addr}, fetch_data);
                exp_fetch_addr = exp_fetch_addr + mem_pkg::block_bytes;
                fetch_count++;
            end
            if (store_done) begin
                store_pulses++;
            end
            if (load_valid) begin
                load_pulses++;
            end
            // fetch owns the bus and a stalled request must not move
            if (!data_on_bus) begin
                if (held) begin
                    check_value("fetch held command", 64'(mem_pkg::bus_load),
                                64'(proc2mem_command));
                    check_value("fetch held addr", 64'(held_addr), 64'(proc2mem_addr));
                end
                if (proc2mem_command != mem_pkg::bus_none) begin
                    check_value("fetch size", 64'(mem_pkg::double_size), 64'(proc2mem_size));
                end
                held      = (proc2mem_command != mem_pkg::bus_none) && (mem_response == '0);
                held_addr = proc2mem_addr;
            end
        end
    endtask

    ////////////////////////////////////////
    // one data operation
    ////////////////////////////////////////

    task automatic run_op(input int op, input mem_pkg::bus_command_t cmd,
                          input mem_pkg::mem_size_t size, input logic [63:0] addr,
                          input logic [63:0] wdata, input logic [63:0] expected);
        string label;
        int    waited;
        logic  accepted;
        logic  done;
        label  = $sformatf("op %0d", op);
        waited = 0;
        while (!data_ready && (waited < op_timeout)) begin
            @(negedge clock);
            waited++;
        end
        if (!data_ready) begin
            report_failure({label, " data_ready never came back"});
        end
        @(posedge clock);
        #1;
        data_command = cmd;
        data_addr    = addr[31:0];
        data_wdata   = wdata;
        data_size    = size;
        // strobe captured on this edge
        @(posedge clock);
        #1;
        data_command = mem_pkg::bus_none;
        data_on_bus  = 1'b1;
        accepted     = 1'b0;
        done         = 1'b0;
        waited       = 0;
        while (!done && (waited < op_timeout)) begin
            @(negedge clock);
            waited++;
            check_value({label, " data_ready busy"}, 64'd0, 64'(data_ready));
            if (!accepted) begin
                // data op wins every cycle until accepted
                check_value({label, " bus command"}, 64'(cmd), 64'(proc2mem_command));
                check_value({label, " bus addr"}, addr, 64'(proc2mem_addr));
                check_value({label, " bus data"}, wdata, proc2mem_data);
                check_value({label, " bus size"}, 64'(size), 64'(proc2mem_size));
                if (mem_response != '0) begin
                    accepted = 1'b1;
                    check_value({label, " store_done on accept"},
                                64'(cmd == mem_pkg::bus_store), 64'(store_done));
                end
            end
            if ((cmd == mem_pkg::bus_store) && store_done) begin
                done = 1'b1;
            end
            if ((cmd == mem_pkg::bus_load) && load_valid) begin
                check_value({label, " load data"}, expected, load_data);
                done = 1'b1;
            end
            @(posedge clock);
            #1;
            if (accepted) begin
                data_on_bus = 1'b0;
            end
        end
        data_on_bus = 1'b0;
        if (!done) begin
            report_failure({label, " never completed"});
        end
        // idle again one cycle after completion
        @(negedge clock);
        check_value({label, " data_ready after"}, 64'd1, 64'(data_ready));
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        logic [6:0] base;
        int         op_count;
        int         store_count;
        int         load_count;
        int         waited;
        clock        = 1'b0;
        reset        = 1'b1;
        data_command = mem_pkg::bus_none;
        data_addr    = '0;
        data_wdata   = '0;
        data_size    = mem_pkg::byte_size;
        checks       = 0;
        mismatches   = 0;
        failures     = 0;
        fetch_count  = 0;
        store_pulses = 0;
        load_pulses  = 0;
        data_on_bus  = 1'b0;
        run_done     = 1'b0;
        $readmemh("sim/mem_port_patterns.txt", pattern_words);
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;
        fork
            watch_bus();
        join_none
        // state right after reset
        @(negedge clock);
        check_value("reset fetch_valid", 64'd0, 64'(fetch_valid));
        check_value("reset load_valid", 64'd0, 64'(load_valid));
        check_value("reset store_done", 64'd0, 64'(store_done));
        check_value("reset data_ready", 64'd1, 64'(data_ready));
        base        = '0;
        op_count    = 0;
        store_count = 0;
        load_count  = 0;
        while ((pattern_words[base] != '0) && (base < 7'd120)) begin
            run_op(op_count,
                   mem_pkg::bus_command_t'(pattern_words[base][1:0]),
                   mem_pkg::mem_size_t'(pattern_words[base + 7'd1][1:0]),
                   pattern_words[base + 7'd2], pattern_words[base + 7'd3],
                   pattern_words[base + 7'd4]);
            if (pattern_words[base][1:0] == 2'h2) begin
                store_count++;
            end else begin
                load_count++;
            end
            op_count++;
            base = base + 7'd5;
        end
        if (op_count == 0) begin
            report_failure("no operations read from the pattern file");
        end
        // let the fetch stream run on alone
        waited = 0;
        while ((fetch_count < fetch_target) && (waited < fetch_timeout)) begin
            @(negedge clock);
            waited++;
        end
        if (fetch_count < fetch_target) begin
            report_failure("fetch stream returned too few blocks");
        end
        check_value("store_done pulses", 64'(store_count), 64'(store_pulses));
        check_value("load_valid pulses", 64'(load_count), 64'(load_pulses));
        run_done = 1'b1;
        $display("checks %0d, mismatches %0d, failures %0d, fetch blocks %0d",
                 checks, mismatches, failures, fetch_count);
        if ((mismatches == 0) && (failures == 0)) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- mem_port.f
hdl/mem_pkg.sv
hdl/mem_req_if.sv
hdl/fetch_unit.sv
hdl/data_unit.sv
hdl/mem_arbiter.sv
hdl/mem_port_top.sv
sim/tb_mem_model.sv
sim/mem_port_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the memory port testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mem_port_tb \
    -f mem_port.f \
    -o mem_port_sim

./obj_dir/mem_port_sim | tee sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation clean"

//--- sim/mem_port_patterns.txt
// one data operation per line, a line of zeros ends the list
// command (1 load, 2 store)  size (0 byte .. 3 double)  address  store data  expected load data
1 3 80000000 0000000000000000 8000000080000000
2 3 80000000 0123456789abcdef 0000000000000000
1 3 80000000 0000000000000000 0123456789abcdef
2 2 80000008 00000000cafef00d 0000000000000000
1 2 80000008 0000000000000000 00000000cafef00d
1 3 80000010 0000000000000000 8000001080000010
1 0 80000018 0000000000000000 8000001880000018
2 0 80000018 00000000000000a5 0000000000000000
1 0 80000018 0000000000000000 00000000000000a5
2 3 80000000 fedcba9876543210 0000000000000000
1 3 80000000 0000000000000000 fedcba9876543210
1 1 80000020 0000000000000000 8000002080000020
2 1 80000020 000000000000beef 0000000000000000
1 1 80000020 0000000000000000 000000000000beef
1 3 80000008 0000000000000000 00000000cafef00d
2 3 80000030 5a5a5a5aa5a5a5a5 0000000000000000
1 3 80000030 0000000000000000 5a5a5a5aa5a5a5a5
0 0 00000000 0000000000000000 0000000000000000
